// File: design/sd_defines.svh
// SD command path constants: frame layout, CRC size and response window
`ifndef SD_DEFINES_SVH
`define SD_DEFINES_SVH

// ==============================
// Frame layout
// ==============================

// Command frame and short response share the same length
`define SD_FRAME_BITS 48

// CRC7 sits in frame bits 7 down to 1, end bit is bit 0
`define SD_CRC_BITS 7
`define SD_CRC_FIRST_BIT 7

// ==============================
// Timing
// ==============================

// Cycles spent looking for the response start bit
`define SD_RESP_TIMEOUT 64

// Wide enough for the frame length and the response window
`define SD_COUNT_BITS 7

`endif

// File: design/sdCmdPkg.sv
// SD command path types: field widths, host request and response, FSM states
package sdCmdPkg;

    `include "sd_defines.svh"

    // Field widths with a meaning of their own
    typedef logic [5:0] cmdIndexT;
    typedef logic [31:0] cmdArgT;
    typedef logic [`SD_CRC_BITS-1:0] crc7T;
    typedef logic [`SD_COUNT_BITS-1:0] bitCountT;

    // Host request, taken on cmdReqValid
    typedef struct packed {
        cmdIndexT index;
        cmdArgT argument;
        logic respExpected;
    } cmdReqT;

    // Unpacked response with status flags
    typedef struct packed {
        cmdIndexT index;
        cmdArgT argument;
        logic crcErr;
        logic timeout;
    } cmdRespT;

    // Command sequencing FSM
    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_START,
        RECV,
        DONE
    } cmdStateT;

endpackage

// File: design/sdCrc7.sv
// Serial CRC7 (x^7 + x^3 + 1) shared by the command and response paths
`timescale 1ns/1ps

module sdCrc7 (
    input  logic              clkFast,
    input  logic              rstN,
    input  logic              clear,
    input  logic              enable,
    input  logic              dataBit,
    output sdCmdPkg::crc7T    crc
);

    logic feedback;

    // Incoming bit against the register MSB
    assign feedback = dataBit ^ crc[6];

    always_ff @(posedge clkFast) begin
        if (!rstN) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            // Taps at x^3 and x^0
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

// File: design/sdBitCounter.sv
// Loadable down-counter timing frame bits and the response window
`timescale 1ns/1ps

module sdBitCounter (
    input  logic                clkFast,
    input  logic                rstN,
    input  logic                load,
    input  sdCmdPkg::bitCountT  loadValue,
    output logic                done
);

    sdCmdPkg::bitCountT count;

    always_ff @(posedge clkFast) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= loadValue;
        end else if (count != '0) begin
            // Parks at zero until the next load
            count <= count - 1'b1;
        end
    end

    assign done = (count == '0);

endmodule

// File: design/sdCmdFsm.sv
// Command sequencing FSM: send, wait for start bit, receive, finish and return the credit
`timescale 1ns/1ps

`include "sd_defines.svh"

module sdCmdFsm (
    input  logic                clkFast,
    input  logic                rstN,
    input  logic                cmdReqValid,
    input  logic                respExpected,
    input  logic                sdCmdIn,
    input  logic                countDone,
    input  logic                respReady,
    output logic                countLoad,
    output sdCmdPkg::bitCountT  countValue,
    output logic                txLoad,
    output logic                txShift,
    output logic                rxShift,
    output logic                cmdCredit,
    output logic                respValid,
    output logic                timeout
);

    sdCmdPkg::cmdStateT state;
    sdCmdPkg::cmdStateT stateNext;
    logic respExpReg;
    logic accept;
    logic startSeen;

    assign accept = (state == sdCmdPkg::IDLE) && cmdReqValid;
    assign startSeen = (state == sdCmdPkg::WAIT_START) && !sdCmdIn;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clkFast) begin
        if (!rstN) begin
            state <= sdCmdPkg::IDLE;
            respExpReg <= 1'b0;
            timeout <= 1'b0;
        end else begin
            state <= stateNext;
            if (accept) begin
                respExpReg <= respExpected;
                timeout <= 1'b0;
            end else if (state == sdCmdPkg::WAIT_START && sdCmdIn && countDone) begin
                timeout <= 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            sdCmdPkg::IDLE: begin
                if (cmdReqValid) begin
                    stateNext = sdCmdPkg::SEND;
                end
            end
            sdCmdPkg::SEND: begin
                if (countDone) begin
                    stateNext = respExpReg ? sdCmdPkg::WAIT_START : sdCmdPkg::DONE;
                end
            end
            sdCmdPkg::WAIT_START: begin
                // A start bit wins over an expiring window
                if (!sdCmdIn) begin
                    stateNext = sdCmdPkg::RECV;
                end else if (countDone) begin
                    stateNext = sdCmdPkg::DONE;
                end
            end
            sdCmdPkg::RECV: begin
                if (countDone) begin
                    stateNext = sdCmdPkg::DONE;
                end
            end
            default: begin
                stateNext = sdCmdPkg::IDLE;
            end
        endcase
    end

    // ==============================
    // Counter control
    // ==============================
    assign countLoad = accept
        || (state == sdCmdPkg::SEND && countDone && respExpReg)
        || startSeen;

    always_comb begin
        if (state == sdCmdPkg::IDLE) begin
            countValue = sdCmdPkg::bitCountT'(`SD_FRAME_BITS - 1);
        end else if (state == sdCmdPkg::SEND) begin
            // The zero cycle is sampled too, so one less gives the full window
            countValue = sdCmdPkg::bitCountT'(`SD_RESP_TIMEOUT - 1);
        end else begin
            // Start bit already taken
            countValue = sdCmdPkg::bitCountT'(`SD_FRAME_BITS - 2);
        end
    end

    // Datapath strobes
    assign txLoad = accept;
    assign txShift = (state == sdCmdPkg::SEND);
    assign rxShift = startSeen || (state == sdCmdPkg::RECV);

    // Credit always comes back, response only when one was asked for
    assign cmdCredit = (state == sdCmdPkg::DONE);
    assign respValid = (state == sdCmdPkg::DONE) && respExpReg && (respReady || timeout);

endmodule

// File: design/sdCmdShifter.sv
// Command frame builder: loads the request and shifts the frame out MSB first with CRC7
`timescale 1ns/1ps

`include "sd_defines.svh"

module sdCmdShifter (
    input  logic              clkFast,
    input  logic              rstN,
    input  logic              load,
    input  logic              shift,
    input  sdCmdPkg::cmdReqT  req,
    output logic              sdCmdOut,
    output logic              sdCmdOe
);

    logic [`SD_FRAME_BITS-1:0] frameReg;
    sdCmdPkg::bitCountT txPos;
    sdCmdPkg::crc7T crc;
    logic crcPhase;
    logic crcEnable;
    logic [2:0] crcSel;

    // Start, transmission bit, index, argument, CRC slot, end bit
    always_ff @(posedge clkFast) begin
        if (load) begin
            frameReg <= {1'b0, 1'b1, req.index, req.argument, {`SD_CRC_BITS{1'b0}}, 1'b1};
        end else if (shift) begin
            frameReg <= {frameReg[`SD_FRAME_BITS-2:0], 1'b1};
        end
    end

    // Frame bit number on the line
    always_ff @(posedge clkFast) begin
        if (!rstN) begin
            txPos <= '0;
        end else if (load) begin
            txPos <= sdCmdPkg::bitCountT'(`SD_FRAME_BITS - 1);
        end else if (shift && txPos != '0) begin
            txPos <= txPos - 1'b1;
        end
    end

    // ==============================
    // CRC splice
    // ==============================
    assign crcEnable = shift && (txPos > `SD_CRC_FIRST_BIT);
    assign crcPhase = (txPos <= `SD_CRC_FIRST_BIT) && (txPos != '0);
    assign crcSel = txPos[2:0] - 3'd1;

    sdCrc7 txCrc_i (
        .clkFast (clkFast),
        .rstN    (rstN),
        .clear   (load),
        .enable  (crcEnable),
        .dataBit (frameReg[`SD_FRAME_BITS-1]),
        .crc     (crc)
    );

    // Line idles high whenever not driving
    always_comb begin
        if (!shift) begin
            sdCmdOut = 1'b1;
        end else if (crcPhase) begin
            sdCmdOut = crc[crcSel];
        end else begin
            sdCmdOut = frameReg[`SD_FRAME_BITS-1];
        end
    end

    assign sdCmdOe = shift;

endmodule

// File: design/sdRespShifter.sv
// Response receiver: shifts in 48 bits, checks CRC7 and end bit, unpacks the fields
`timescale 1ns/1ps

`include "sd_defines.svh"

module sdRespShifter (
    input  logic               clkFast,
    input  logic               rstN,
    input  logic               shift,
    input  logic               sdCmdIn,
    input  logic               timeout,
    output logic               respReady,
    output sdCmdPkg::cmdRespT  resp
);

    logic [`SD_FRAME_BITS-1:0] shiftReg;
    sdCmdPkg::bitCountT rxCount;
    sdCmdPkg::crc7T crc;
    logic crcEnable;
    logic lastBit;
    logic crcErrReg;

    assign lastBit = shift && (rxCount == `SD_FRAME_BITS - 1);

    // Start bit through argument go into the CRC
    assign crcEnable = shift && (rxCount < `SD_FRAME_BITS - `SD_CRC_BITS - 1);

    always_ff @(posedge clkFast) begin
        if (shift) begin
            shiftReg <= {shiftReg[`SD_FRAME_BITS-2:0], sdCmdIn};
        end
    end

    // ==============================
    // Bit count and result flag
    // ==============================
    always_ff @(posedge clkFast) begin
        if (!rstN) begin
            rxCount <= '0;
            respReady <= 1'b0;
        end else begin
            respReady <= lastBit;
            if (lastBit) begin
                rxCount <= '0;
            end else if (shift) begin
                rxCount <= rxCount + 1'b1;
            end
        end
    end

    // On the end bit, the register low bits already hold the received CRC
    always_ff @(posedge clkFast) begin
        if (lastBit) begin
            crcErrReg <= (shiftReg[`SD_CRC_FIRST_BIT-1:0] != crc) || !sdCmdIn;
        end
    end

    // Cleared once the result is out, ready for the next response
    sdCrc7 rxCrc_i (
        .clkFast (clkFast),
        .rstN    (rstN),
        .clear   (respReady),
        .enable  (crcEnable),
        .dataBit (sdCmdIn),
        .crc     (crc)
    );

    // Field unpack
    assign resp.index = shiftReg[45:40];
    assign resp.argument = shiftReg[39:8];
    assign resp.crcErr = crcErrReg && !timeout;
    assign resp.timeout = timeout;

endmodule

// File: design/sdCmdCtrl.sv
// SD host command controller: sends a command frame and collects the short response
`timescale 1ns/1ps

module sdCmdCtrl (
    input  logic               clkFast,
    input  logic               rstN,
    input  logic               cmdReqValid,
    input  sdCmdPkg::cmdReqT   cmdReq,
    input  logic               sdCmdIn,
    output logic               cmdCredit,
    output logic               respValid,
    output sdCmdPkg::cmdRespT  resp,
    output logic               sdCmdOut,
    output logic               sdCmdOe
);

    logic countLoad;
    logic countDone;
    sdCmdPkg::bitCountT countValue;
    logic txLoad;
    logic txShift;
    logic rxShift;
    logic respReady;
    logic timeout;

    // ==============================
    // Control
    // ==============================
    sdCmdFsm fsm_i (
        .clkFast      (clkFast),
        .rstN         (rstN),
        .cmdReqValid  (cmdReqValid),
        .respExpected (cmdReq.respExpected),
        .sdCmdIn      (sdCmdIn),
        .countDone    (countDone),
        .respReady    (respReady),
        .countLoad    (countLoad),
        .countValue   (countValue),
        .txLoad       (txLoad),
        .txShift      (txShift),
        .rxShift      (rxShift),
        .cmdCredit    (cmdCredit),
        .respValid    (respValid),
        .timeout      (timeout)
    );

    sdBitCounter counter_i (
        .clkFast   (clkFast),
        .rstN      (rstN),
        .load      (countLoad),
        .loadValue (countValue),
        .done      (countDone)
    );

    // ==============================
    // Datapath
    // ==============================
    sdCmdShifter cmdShifter_i (
        .clkFast  (clkFast),
        .rstN     (rstN),
        .load     (txLoad),
        .shift    (txShift),
        .req      (cmdReq),
        .sdCmdOut (sdCmdOut),
        .sdCmdOe  (sdCmdOe)
    );

    sdRespShifter respShifter_i (
        .clkFast   (clkFast),
        .rstN      (rstN),
        .shift     (rxShift),
        .sdCmdIn   (sdCmdIn),
        .timeout   (timeout),
        .respReady (respReady),
        .resp      (resp)
    );

endmodule

// File: test/sdCmdCtrl_chk.sv
// Bound protocol checks for the SD command controller: host credit use and command line framing
`timescale 1ns/1ps

`include "sd_defines.svh"

module sdCmdCtrlChk (
    input logic clkFast,
    input logic rstN,
    input logic cmdReqValid,
    input logic cmdCredit,
    input logic sdCmdOut,
    input logic sdCmdOe
);

    logic creditHeld;
    logic oeLast;
    int oeCount;

    // Host side credit, one after reset
    always_ff @(posedge clkFast) begin
        if (!rstN) begin
            creditHeld <= 1'b1;
            oeLast <= 1'b0;
            oeCount <= 0;
        end else begin
            if (cmdCredit) begin
                creditHeld <= 1'b1;
            end else if (cmdReqValid) begin
                creditHeld <= 1'b0;
            end
            oeLast <= sdCmdOe;
            oeCount <= sdCmdOe ? oeCount + 1 : 0;
        end
    end

    // ==============================
    // Properties
    // ==============================
    assert property (@(posedge clkFast) disable iff (!rstN) cmdReqValid |-> creditHeld)
        else $error("cmdReqValid asserted while the host holds no credit");

    assert property (@(posedge clkFast) disable iff (!rstN)
        sdCmdOe |-> oeCount < `SD_FRAME_BITS)
        else $error("sdCmdOe held longer than one frame");

    assert property (@(posedge clkFast) disable iff (!rstN)
        (oeLast && !sdCmdOe) |-> oeCount == `SD_FRAME_BITS)
        else $error("sdCmdOe dropped before a full frame");

    assert property (@(posedge clkFast) disable iff (!rstN)
        (sdCmdOe && oeCount == 0) |-> !sdCmdOut)
        else $error("Frame start bit is not 0");

    assert property (@(posedge clkFast) disable iff (!rstN)
        (sdCmdOe && oeCount == 1) |-> sdCmdOut)
        else $error("Frame transmission bit is not 1");

endmodule

// File: test/sdCmdCtrlTb.sv
// Testbench for the SD command controller: LFSR stimulus, card model and reference checks
`timescale 1ns/1ps

`include "sd_defines.svh"

module sdCmdCtrlTb;

    localparam int NUM_CMDS = 40;
    localparam int CYCLE_LIMIT = 300;

    logic clkFast = 1'b0;
    logic rstN;
    logic cmdReqValid;
    sdCmdPkg::cmdReqT cmdReq;
    logic sdCmdIn;
    logic cmdCredit;
    logic respValid;
    sdCmdPkg::cmdRespT resp;
    logic sdCmdOut;
    logic sdCmdOe;

    logic [31:0] lfsr;
    int errCount;
    int testCount;
    int failCount;
    bit timedOut;

    always #5 clkFast = ~clkFast;

    sdCmdCtrl sdCmdCtrl_i (
        .clkFast     (clkFast),
        .rstN        (rstN),
        .cmdReqValid (cmdReqValid),
        .cmdReq      (cmdReq),
        .sdCmdIn     (sdCmdIn),
        .cmdCredit   (cmdCredit),
        .respValid   (respValid),
        .resp        (resp),
        .sdCmdOut    (sdCmdOut),
        .sdCmdOe     (sdCmdOe)
    );

    bind sdCmdCtrl sdCmdCtrlChk sdCmdCtrlChk_i (
        .clkFast     (clkFast),
        .rstN        (rstN),
        .cmdReqValid (cmdReqValid),
        .cmdCredit   (cmdCredit),
        .sdCmdOut    (sdCmdOut),
        .sdCmdOe     (sdCmdOe)
    );

    // ==============================
    // Helpers
    // ==============================

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = nextLfsr(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // CRC7 over 40 bits, MSB first, polynomial x^7 + x^3 + 1
    function automatic logic [6:0] crc7Of(input logic [39:0] bits);
        logic [39:0] data;
        logic [6:0] crc;
        logic fb;
        data = bits;
        crc = '0;
        for (int i = 0; i < 40; i++) begin
            fb = data[39] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
            data = {data[38:0], 1'b0};
        end
        return crc;
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        errCount++;
    endtask

    task automatic checkReset();
        @(negedge clkFast);
        if (sdCmdOe !== 1'b0) reportMismatch("sdCmdOe", 64'(1'b0), 64'(sdCmdOe));
        if (cmdCredit !== 1'b0) reportMismatch("cmdCredit", 64'(1'b0), 64'(cmdCredit));
        if (respValid !== 1'b0) reportMismatch("respValid", 64'(1'b0), 64'(respValid));
        if (sdCmdOut !== 1'b1) reportMismatch("sdCmdOut", 64'(1'b1), 64'(sdCmdOut));
        testCount++;
        if (errCount != 0) failCount++;
        $display("Reset state: %s", (errCount == 0) ? "ok" : "FAILED");
        @(posedge clkFast);
    endtask

    // One random command, cycle by cycle, with the card replying on its own
    task automatic runCommand(input int num);
        sdCmdPkg::cmdReqT req;
        logic [39:0] head;
        logic [47:0] expFrame;
        logic [47:0] frameCap;
        logic [47:0] replyFrame;
        logic [6:0] flipMask;
        logic expOe;
        logic expCredit;
        int delay;
        int expDone;
        int cyc;
        int capCount;
        int replyStart;
        int replyEnd;
        int errBefore;
        bit corrupt;
        bit creditSeen;
        req.index = sdCmdPkg::cmdIndexT'(takeBits(6));
        req.argument = takeBits(32);
        req.respExpected = (takeBits(2) != '0);
        delay = int'(takeBits(7) % 32'd80) + 1;
        corrupt = (takeBits(3) == '0);
        flipMask = 7'd1 << (takeBits(3) % 32'd7);
        if (!corrupt) flipMask = '0;
        head = {2'b01, req.index, req.argument};
        expFrame = {head, crc7Of(head), 1'b1};
        // Frame, window and receive lengths in line cycles
        if (!req.respExpected) begin
            expDone = `SD_FRAME_BITS + 1;
        end else if (delay <= `SD_RESP_TIMEOUT) begin
            expDone = `SD_FRAME_BITS + delay + `SD_FRAME_BITS;
        end else begin
            expDone = `SD_FRAME_BITS + `SD_RESP_TIMEOUT + 1;
        end
        errBefore = errCount;
        frameCap = '0;
        replyFrame = '1;
        capCount = 0;
        replyStart = CYCLE_LIMIT;
        replyEnd = 0;
        creditSeen = 1'b0;
        cmdReqValid <= 1'b1;
        cmdReq <= req;
        @(posedge clkFast);
        cmdReqValid <= 1'b0;
        cyc = 1;
        while (!(creditSeen && cyc >= replyEnd) && cyc < CYCLE_LIMIT) begin
            // Card drives its reply MSB first
            if (cyc >= replyStart && cyc < replyEnd) begin
                sdCmdIn <= replyFrame[47];
                replyFrame = {replyFrame[46:0], 1'b1};
            end else begin
                sdCmdIn <= 1'b1;
            end
            @(negedge clkFast);
            expOe = (cyc >= 1 && cyc <= `SD_FRAME_BITS);
            expCredit = (cyc == expDone);
            if (sdCmdOe !== expOe) reportMismatch("sdCmdOe", 64'(expOe), 64'(sdCmdOe));
            if (cmdCredit !== expCredit)
                reportMismatch("cmdCredit", 64'(expCredit), 64'(cmdCredit));
            if (respValid !== (expCredit && req.respExpected))
                reportMismatch("respValid", 64'(expCredit && req.respExpected), 64'(respValid));
            if (cmdCredit) creditSeen = 1'b1;
            if (respValid && expCredit && req.respExpected) begin
                if (delay <= `SD_RESP_TIMEOUT) begin
                    if (resp.index !== req.index)
                        reportMismatch("resp.index", 64'(req.index), 64'(resp.index));
                    if (resp.argument !== ~req.argument)
                        reportMismatch("resp.argument", 64'(~req.argument), 64'(resp.argument));
                    if (resp.crcErr !== corrupt)
                        reportMismatch("resp.crcErr", 64'(corrupt), 64'(resp.crcErr));
                    if (resp.timeout !== 1'b0)
                        reportMismatch("resp.timeout", 64'(1'b0), 64'(resp.timeout));
                end else begin
                    if (resp.timeout !== 1'b1)
                        reportMismatch("resp.timeout", 64'(1'b1), 64'(resp.timeout));
                    if (resp.crcErr !== 1'b0)
                        reportMismatch("resp.crcErr", 64'(1'b0), 64'(resp.crcErr));
                end
            end
            // Card captures the frame and prepares its echo
            if (sdCmdOe && capCount < `SD_FRAME_BITS) begin
                frameCap = {frameCap[46:0], sdCmdOut};
                capCount++;
                if (capCount == `SD_FRAME_BITS && req.respExpected) begin
                    head = {2'b00, frameCap[45:40], ~frameCap[39:8]};
                    replyFrame = {head, crc7Of(head) ^ flipMask, 1'b1};
                    replyStart = cyc + delay;
                    replyEnd = replyStart + `SD_FRAME_BITS;
                end
            end
            @(posedge clkFast);
            cyc++;
        end
        if (!creditSeen) begin
            $display("Command %0d: no cmdCredit within %0d cycles", num, CYCLE_LIMIT);
            errCount++;
            timedOut = 1'b1;
        end
        if (capCount != `SD_FRAME_BITS) begin
            $display("Command %0d: card captured %0d frame bits instead of %0d",
                     num, capCount, `SD_FRAME_BITS);
            errCount++;
        end else if (frameCap !== expFrame) begin
            reportMismatch("frame", 64'(expFrame), 64'(frameCap));
        end
        testCount++;
        if (errCount != errBefore) failCount++;
        $display("Command %0d idx=%0d resp=%0b delay=%0d corrupt=%0b: %s", num, req.index,
                 req.respExpected, delay, corrupt, (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        lfsr = 32'h3215_762f;
        errCount = 0;
        testCount = 0;
        failCount = 0;
        timedOut = 1'b0;
        rstN = 1'b0;
        cmdReqValid = 1'b0;
        cmdReq = '0;
        sdCmdIn = 1'b1;
        repeat (10) @(posedge clkFast);
        rstN <= 1'b1;
        checkReset();
        for (int n = 0; n < NUM_CMDS && !timedOut; n++) begin
            runCommand(n);
        end
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/sdCmdPkg.sv
design/sdCrc7.sv
design/sdBitCounter.sv
design/sdCmdFsm.sv
design/sdCmdShifter.sv
design/sdRespShifter.sv
design/sdCmdCtrl.sv
test/sdCmdCtrl_chk.sv
test/sdCmdCtrlTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= sdCmdCtrlTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
